// ==== tb.f ====
common/snn_pkg.sv
in_spike_buf/in_spike_buf.sv
src/apb_spike_regs.sv
crossbar/xbar_seq.sv
crossbar/neuron_unit.sv
src/spike_collector.sv
src/snn_core_top.sv
sim/tb_clk_gen.sv
sim/snn_core_tb.sv

// ==== sim/snn_core_tb.sv ====
// Assumes package default sizes; every APB transfer leaves one idle cycle after it
`timescale 1ns/100ps

module snn_core_tb;

	import snn_pkg::*;

	localparam int unsigned RAND_SEED = 32'h50e75b60;
	localparam int APB_TIMEOUT   = 8;
	localparam int BUSY_POLLS    = 40;
	localparam int DRAIN_TIMEOUT = 20;
	localparam int RST_TIMEOUT   = 50;
	localparam int WT_BITS       = NUM_NEURONS * NUM_AXONS * WEIGHT_W;

	logic              clk;
	logic              rst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic              pready;
	logic              pslverr;

	// Model of what the host has loaded
	logic [NUM_AXONS-1:0] spikes_m;
	logic [WT_BITS-1:0]   wts_m;
	int                   thresh_m;

	// Pending checks for the compare process
	string             name_q[$];
	logic [APB_DW-1:0] got_q[$];
	logic [APB_DW-1:0] exp_q[$];

	int err_cnt;
	int chk_cnt;
	int test_cnt;
	int test_base;

	tb_clk_gen #(.PERIOD_NS(4.0), .RST_CYCLES(5)) u_clk_gen (
		.clk_o(clk), .rst_n_o(rst_n)
	);

	snn_core_top #(
		.NUM_AXONS(NUM_AXONS), .AXON_AW(AXON_AW), .NUM_NEURONS(NUM_NEURONS),
		.WEIGHT_W(WEIGHT_W), .POT_W(POT_W)
	) UUT (
		.clk_i(clk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
		.pready_o(pready), .pslverr_o(pslverr)
	);

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic int wt_lsb(input int n, input int a);
		return (n * NUM_AXONS + a) * WEIGHT_W;
	endfunction

	// Saturating sum per neuron with fire at or above threshold
	function automatic logic [NUM_NEURONS-1:0] ref_fire(
		input logic [NUM_AXONS-1:0] spk,
		input logic [WT_BITS-1:0]   wts,
		input int                   thr
	);
		logic [NUM_NEURONS-1:0] fire;
		int acc;
		int w;
		int pmax;
		int pmin;
		pmax = (1 << (POT_W - 1)) - 1;
		pmin = -(1 << (POT_W - 1));
		fire = '0;
		for (int n = 0; n < NUM_NEURONS; n++) begin
			acc = 0;
			for (int a = 0; a < NUM_AXONS; a++) begin
				if (spk[a]) begin
					w = $signed(wts[wt_lsb(n, a) +: WEIGHT_W]);
					acc = acc + w;
					if (acc > pmax) acc = pmax;
					if (acc < pmin) acc = pmin;
				end
			end
			fire[n] = (acc >= thr);
		end
		return fire;
	endfunction

	// ----------------------------------------
	// Compare process
	// ----------------------------------------
	always @(posedge clk) begin : compare_results
		string             nm;
		logic [APB_DW-1:0] got;
		logic [APB_DW-1:0] exp;
		while (got_q.size() > 0) begin
			nm  = name_q.pop_front();
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			chk_cnt++;
			if (got !== exp) begin
				$display("error %s: got 0x%h expected 0x%h", nm, got, exp);
				err_cnt++;
			end
		end
	end

	task automatic expect_val(input string nm, input logic [APB_DW-1:0] got,
			input logic [APB_DW-1:0] exp);
		name_q.push_back(nm);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	// ----------------------------------------
	// APB host
	// ----------------------------------------
	task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata,
			output logic err);
		int n;
		// Setup
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		// Access phase held until pready
		@(posedge clk);
		penable <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!pready && n < APB_TIMEOUT) begin
			@(posedge clk);
			@(negedge clk);
			n++;
		end
		if (!pready) begin
			$display("APB access to 0x%h never saw pready", addr);
			err_cnt++;
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
			output logic err);
		logic [APB_DW-1:0] unused;
		apb_xfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
			output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	// ----------------------------------------
	// Step helpers
	// ----------------------------------------
	// Even neurons reach 100 exactly while odd ones stop at 99
	task automatic directed_model();
		spikes_m = 16'h0123;
		wts_m    = '0;
		thresh_m = 100;
		for (int i = 0; i < NUM_NEURONS; i++) begin
			wts_m[wt_lsb(i, 0) +: WEIGHT_W] = 8'sd50;
			wts_m[wt_lsb(i, 1) +: WEIGHT_W] = (i % 2 == 0) ? 8'sd50 : 8'sd49;
			wts_m[wt_lsb(i, 5) +: WEIGHT_W] = 8'sd30;
			wts_m[wt_lsb(i, 8) +: WEIGHT_W] = -8'sd30;
			// Silent axon that must not count
			wts_m[wt_lsb(i, 2) +: WEIGHT_W] = -8'sd100;
		end
	endtask

	task automatic load_model();
		logic err;
		for (int a = 0; a < NUM_AXONS; a++) begin
			apb_write(SPIKE_BASE + APB_AW'(4 * a), APB_DW'(spikes_m[a]), err);
			expect_val("pslverr_o", err, 0);
		end
		for (int n = 0; n < NUM_NEURONS; n++) begin
			for (int a = 0; a < NUM_AXONS; a++) begin
				apb_write(WEIGHT_BASE + APB_AW'((n << WT_NRN_LSB) + 4 * a),
					APB_DW'(wts_m[wt_lsb(n, a) +: WEIGHT_W]), err);
				expect_val("pslverr_o", err, 0);
			end
		end
		apb_write(ADDR_THRESH, APB_DW'(thresh_m), err);
		expect_val("pslverr_o", err, 0);
	endtask

	task automatic start_step();
		logic err;
		apb_write(ADDR_CTRL, 32'h1, err);
		expect_val("pslverr_o", err, 0);
	endtask

	// Poll status until busy drops and expect done by then
	task automatic wait_idle();
		logic [APB_DW-1:0] rd;
		logic              err;
		int                polls;
		polls = 0;
		rd    = '1;
		while (rd[0] && polls < BUSY_POLLS) begin
			apb_read(ADDR_CTRL, rd, err);
			polls++;
		end
		if (rd[0]) begin
			$display("Step did not finish, busy still high after %0d status reads", polls);
			err_cnt++;
		end
		expect_val("prdata_o status", rd, 32'h2);
	endtask

	task automatic check_result();
		logic [APB_DW-1:0] rd;
		logic              err;
		apb_read(ADDR_OUT, rd, err);
		expect_val("pslverr_o", err, 0);
		expect_val("prdata_o out_spikes", rd, ref_fire(spikes_m, wts_m, thresh_m));
	endtask

	task automatic check_learn(input logic [NUM_AXONS-1:0] exp_vec);
		logic [APB_DW-1:0]    rd;
		logic                 err;
		logic [NUM_AXONS-1:0] got;
		for (int a = 0; a < NUM_AXONS; a++) begin
			apb_read(LEARN_BASE + APB_AW'(4 * a), rd, err);
			expect_val("pslverr_o", err, 0);
			got[a] = rd[0];
		end
		expect_val("prdata_o learn", got, exp_vec);
	endtask

	// Let queued checks finish before reporting the test
	task automatic close_test(input string nm);
		int n;
		n = 0;
		while (got_q.size() > 0 && n < DRAIN_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (got_q.size() > 0) begin
			$display("Compare process did not drain its queue in %s", nm);
			err_cnt++;
		end
		test_cnt++;
		if (err_cnt == test_base) $display("Test %0d %s: passed", test_cnt, nm);
		else $display("Test %0d %s: failed, %0d errors", test_cnt, nm, err_cnt - test_base);
		test_base = err_cnt;
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin : stimulus
		logic [APB_DW-1:0]    rd;
		logic                 err;
		logic [NUM_AXONS-1:0] prev;
		int unsigned          seed_val;
		int                   n;
		psel      <= 1'b0;
		penable   <= 1'b0;
		pwrite    <= 1'b0;
		paddr     <= '0;
		pwdata    <= '0;
		err_cnt   = 0;
		chk_cnt   = 0;
		test_cnt  = 0;
		test_base = 0;
		seed_val  = $urandom(RAND_SEED);
		n = 0;
		while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			$display("Reset never released");
			err_cnt++;
		end

		// Everything reads zero after reset
		apb_read(ADDR_CTRL, rd, err);
		expect_val("prdata_o status", rd, 0);
		expect_val("pslverr_o", err, 0);
		apb_read(ADDR_OUT, rd, err);
		expect_val("prdata_o out_spikes", rd, 0);
		expect_val("pslverr_o", err, 0);
		apb_read(ADDR_THRESH, rd, err);
		expect_val("prdata_o thresh", rd, 0);
		expect_val("pslverr_o", err, 0);
		check_learn('0);
		close_test("reset values");

		directed_model();
		load_model();
		start_step();
		wait_idle();
		check_result();
		check_learn(spikes_m);
		close_test("directed threshold step");

		// Random steps; learn must keep the old spikes until the next save
		for (int i = 0; i < 20; i++) begin
			prev     = spikes_m;
			spikes_m = NUM_AXONS'($urandom);
			for (int k = 0; k < NUM_NEURONS * NUM_AXONS; k++) begin
				wts_m[k * WEIGHT_W +: WEIGHT_W] = WEIGHT_W'($urandom);
			end
			thresh_m = int'($urandom_range(400)) - 200;
			load_model();
			check_learn(prev);
			start_step();
			wait_idle();
			check_result();
			check_learn(spikes_m);
		end
		close_test("random steps and learn readback");

		// Known model where any leaked write changes the result
		directed_model();
		load_model();
		// Error responses while idle
		apb_read(12'h0F0, rd, err);
		expect_val("pslverr_o", err, 1);
		apb_write(12'h800, 32'h1, err);
		expect_val("pslverr_o", err, 1);
		apb_write(ADDR_OUT, 32'hF, err);
		expect_val("pslverr_o", err, 1);
		apb_write(LEARN_BASE, 32'h1, err);
		expect_val("pslverr_o", err, 1);
		// Would clear axon 0 if the unaligned write went through
		apb_write(SPIKE_BASE + 12'h2, 32'h0, err);
		expect_val("pslverr_o", err, 1);
		// Writes during the scan are refused
		start_step();
		apb_write(SPIKE_BASE, APB_DW'(~spikes_m[0]), err);
		expect_val("pslverr_o", err, 1);
		// Neuron 1 would reach the threshold with this weight
		apb_write(WEIGHT_BASE + APB_AW'((1 << WT_NRN_LSB) + 4),
			APB_DW'(wts_m[wt_lsb(1, 1) +: WEIGHT_W] + 1), err);
		expect_val("pslverr_o", err, 1);
		apb_write(ADDR_THRESH, APB_DW'(thresh_m + 1), err);
		expect_val("pslverr_o", err, 1);
		wait_idle();
		check_result();
		check_learn(spikes_m);
		apb_read(ADDR_THRESH, rd, err);
		expect_val("prdata_o thresh", rd, APB_DW'(thresh_m));
		// Next step sees the model unchanged
		start_step();
		wait_idle();
		check_result();
		check_learn(spikes_m);
		close_test("error responses");

		// Largest weights against the top of the range
		spikes_m = '1;
		for (int k = 0; k < NUM_NEURONS * NUM_AXONS; k++) begin
			wts_m[k * WEIGHT_W +: WEIGHT_W] = {1'b0, {(WEIGHT_W - 1){1'b1}}};
		end
		thresh_m = (1 << (POT_W - 1)) - 1;
		load_model();
		start_step();
		wait_idle();
		check_result();
		// Smallest weights against the negative limit
		for (int k = 0; k < NUM_NEURONS * NUM_AXONS; k++) begin
			wts_m[k * WEIGHT_W +: WEIGHT_W] = {1'b1, {(WEIGHT_W - 1){1'b0}}};
		end
		thresh_m = -(1 << (POT_W - 1));
		load_model();
		start_step();
		wait_idle();
		check_result();
		close_test("saturation limits");

		$display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== sim/tb_clk_gen.sv ====
// Testbench only; reset releases on the rising edge after RST_CYCLES clock periods
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter real PERIOD_NS  = 4.0,
	parameter int  RST_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_n_o
);

	// Free running clock
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// Reset low from time zero
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== src/snn_core_top.sv ====
// Sizes must match the package defaults, which fix the struct field widths
`timescale 1ns/100ps

module snn_core_top #(
	parameter int NUM_AXONS   = snn_pkg::NUM_AXONS,
	parameter int AXON_AW     = snn_pkg::AXON_AW,
	parameter int NUM_NEURONS = snn_pkg::NUM_NEURONS,
	parameter int WEIGHT_W    = snn_pkg::WEIGHT_W,
	parameter int POT_W       = snn_pkg::POT_W
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        psel_i,
	input  logic                        penable_i,
	input  logic                        pwrite_i,
	input  logic [snn_pkg::APB_AW-1:0]  paddr_i,
	input  logic [snn_pkg::APB_DW-1:0]  pwdata_i,
	output logic [snn_pkg::APB_DW-1:0]  prdata_o,
	output logic                        pready_o,
	output logic                        pslverr_o
);

	import snn_pkg::*;

	spk_wr_t                 spk_wr;
	wt_wr_t                  wt_wr;
	axon_rd_t                rd_req;
	spike_beat_t             beat;
	logic signed [POT_W-1:0] thresh;
	logic                    start, busy, save, eval_done, lrn_spike;
	logic [AXON_AW-1:0]      lrn_addr;
	logic [NUM_NEURONS-1:0]  fire, fire_valid, out_spikes;

	apb_spike_regs u_regs (
		.clk_i, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
		.busy_i(busy), .eval_done_i(eval_done), .out_spikes_i(out_spikes),
		.lrn_spike_i(lrn_spike), .prdata_o, .pready_o, .pslverr_o,
		.thresh_o(thresh), .start_o(start), .spk_wr_o(spk_wr),
		.wt_wr_o(wt_wr), .lrn_addr_o(lrn_addr)
	);

	xbar_seq #(.NUM_AXONS(NUM_AXONS), .AXON_AW(AXON_AW)) u_seq (
		.clk_i, .rst_n_i, .start_i(start), .eval_done_i(eval_done),
		.rd_req_o(rd_req), .save_o(save), .busy_o(busy)
	);

	in_spike_buf #(.NUM_AXONS(NUM_AXONS), .AXON_AW(AXON_AW)) u_buf (
		.clk_i, .rst_n_i, .spk_wr_i(spk_wr), .rd_req_i(rd_req), .save_i(save),
		.lrn_addr_i(lrn_addr), .beat_o(beat), .lrn_spike_o(lrn_spike)
	);

	// Row of neurons sharing one beat stream
	for (genvar n = 0; n < NUM_NEURONS; n++) begin : g_neuron
		neuron_unit #(
			.NEURON_ID(n), .NUM_AXONS(NUM_AXONS), .WEIGHT_W(WEIGHT_W), .POT_W(POT_W)
		) u_neuron (
			.clk_i, .rst_n_i, .wt_wr_i(wt_wr), .beat_i(beat), .thresh_i(thresh),
			.fire_o(fire[n]), .fire_valid_o(fire_valid[n])
		);
	end

	spike_collector #(.NUM_NEURONS(NUM_NEURONS)) u_collect (
		.clk_i, .rst_n_i, .fire_i(fire), .fire_valid_i(fire_valid),
		.out_spikes_o(out_spikes), .eval_done_o(eval_done)
	);

endmodule

// ==== src/spike_collector.sv ====
// Expects every neuron to report fire_valid in the same cycle
`timescale 1ns/100ps

module spike_collector #(
	parameter int NUM_NEURONS = snn_pkg::NUM_NEURONS
) (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic [NUM_NEURONS-1:0] fire_i,
	input  logic [NUM_NEURONS-1:0] fire_valid_i,
	output logic [NUM_NEURONS-1:0] out_spikes_o,
	output logic                   eval_done_o
);

	logic all_valid;

	assign all_valid = &fire_valid_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_spikes_o <= '0;
			eval_done_o  <= 1'b0;
		end else begin
			// Output word holds until the next step
			if (all_valid) begin
				out_spikes_o <= fire_i;
			end
			eval_done_o <= all_valid;
		end
	end

	// Neuron row runs in lockstep
	a_valids_aligned: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(fire_valid_i == '0) || (fire_valid_i == '1)
	);

endmodule

// ==== crossbar/neuron_unit.sv ====
// Potential restarts at zero each step; no leak, no refractory period
`timescale 1ns/100ps

module neuron_unit #(
	parameter int NEURON_ID = 0,
	parameter int NUM_AXONS = snn_pkg::NUM_AXONS,
	parameter int WEIGHT_W  = snn_pkg::WEIGHT_W,
	parameter int POT_W     = snn_pkg::POT_W
) (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  snn_pkg::wt_wr_t          wt_wr_i,
	input  snn_pkg::spike_beat_t     beat_i,
	input  logic signed [POT_W-1:0]  thresh_i,
	output logic                     fire_o,
	output logic                     fire_valid_o
);

	// Signed limits of the potential
	localparam logic signed [POT_W-1:0] POT_MAX = {1'b0, {(POT_W-1){1'b1}}};
	localparam logic signed [POT_W-1:0] POT_MIN = {1'b1, {(POT_W-1){1'b0}}};

	logic signed [WEIGHT_W-1:0] wmem [NUM_AXONS];
	logic signed [POT_W-1:0]    pot_q;
	logic signed [POT_W-1:0]    w_ext;
	logic signed [POT_W:0]      sum_wide;
	logic signed [POT_W-1:0]    sum_sat;

	// ----------------------------------------
	// Saturating add
	// ----------------------------------------
	always_comb begin
		// Zero contribution when the axon is silent
		w_ext    = beat_i.spike ? POT_W'(wmem[beat_i.axon]) : '0;
		sum_wide = {pot_q[POT_W-1], pot_q} + {w_ext[POT_W-1], w_ext};
		sum_sat  = sum_wide[POT_W-1:0];
		// Top two bits differ on overflow
		if (sum_wide[POT_W] != sum_wide[POT_W-1]) begin
			sum_sat = sum_wide[POT_W] ? POT_MIN : POT_MAX;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_AXONS; i++) wmem[i] <= '0;
			pot_q        <= '0;
			fire_o       <= 1'b0;
			fire_valid_o <= 1'b0;
		end else begin
			// Only the write addressed to this neuron
			if (wt_wr_i.en && wt_wr_i.neuron == NEURON_ID) begin
				wmem[wt_wr_i.axon] <= wt_wr_i.data;
			end
			fire_valid_o <= beat_i.valid & beat_i.last;
			if (beat_i.valid) begin
				if (beat_i.last) begin
					// Fire at or above threshold
					fire_o <= (sum_sat >= thresh_i);
					pot_q  <= '0;
				end else begin
					pot_q <= sum_sat;
				end
			end
		end
	end

	a_fire_valid_pulse: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		fire_valid_o |=> !fire_valid_o
	);

endmodule

// ==== crossbar/xbar_seq.sv ====
// Start is taken only in IDLE; busy drops in the SAVE cycle
`timescale 1ns/100ps

module xbar_seq #(
	parameter int NUM_AXONS = snn_pkg::NUM_AXONS,
	parameter int AXON_AW   = snn_pkg::AXON_AW
) (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               start_i,
	input  logic               eval_done_i,
	output snn_pkg::axon_rd_t  rd_req_o,
	output logic               save_o,
	output logic               busy_o
);

	import snn_pkg::*;

	seq_state_e         state_q;
	seq_state_e         state_nxt;
	logic [AXON_AW-1:0] addr_q;
	logic               last;

	assign last = (addr_q == AXON_AW'(NUM_AXONS - 1));

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb begin
		state_nxt = state_q;
		case (state_q)
			IDLE: if (start_i) state_nxt = SCAN;
			SCAN: if (last) state_nxt = EVAL;
			// Wait for the collector
			EVAL: if (eval_done_i) state_nxt = SAVE;
			SAVE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			addr_q  <= '0;
		end else begin
			state_q <= state_nxt;
			// Axon counter, back to zero after the last one
			if (state_q == SCAN) begin
				addr_q <= last ? '0 : addr_q + 1'b1;
			end else begin
				addr_q <= '0;
			end
		end
	end

	// Outputs
	always_comb begin
		rd_req_o.en   = (state_q == SCAN);
		rd_req_o.last = (state_q == SCAN) & last;
		rd_req_o.addr = addr_q;
	end

	assign save_o = (state_q == SAVE);
	assign busy_o = (state_q == SCAN) || (state_q == EVAL);

	a_scan_addr_range: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(state_q == SCAN) |-> (addr_q < NUM_AXONS)
	);

endmodule

// ==== src/apb_spike_regs.sv ====
// APB3 slave without wait states; unaligned or unmapped addresses give pslverr
`timescale 1ns/100ps

module apb_spike_regs (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [snn_pkg::APB_AW-1:0]        paddr_i,
	input  logic [snn_pkg::APB_DW-1:0]        pwdata_i,
	input  logic                              busy_i,
	input  logic                              eval_done_i,
	input  logic [snn_pkg::NUM_NEURONS-1:0]   out_spikes_i,
	input  logic                              lrn_spike_i,
	output logic [snn_pkg::APB_DW-1:0]        prdata_o,
	output logic                              pready_o,
	output logic                              pslverr_o,
	output logic signed [snn_pkg::POT_W-1:0]  thresh_o,
	output logic                              start_o,
	output snn_pkg::spk_wr_t                  spk_wr_o,
	output snn_pkg::wt_wr_t                   wt_wr_o,
	output logic [snn_pkg::AXON_AW-1:0]       lrn_addr_o
);

	import snn_pkg::*;

	apb_region_e       region;
	logic              setup;
	logic              err;
	logic              wr_ok;
	logic              done_q;
	logic [APB_DW-1:0] rd_data;

	// Map a byte address onto a register region
	function automatic apb_region_e decode(input logic [APB_AW-1:0] a);
		apb_region_e r;
		r = BAD;
		if (a[1:0] != 2'b00) r = BAD;
		else if (a == ADDR_CTRL) r = REG_CTRL;
		else if (a == ADDR_THRESH) r = REG_THRESH;
		else if (a == ADDR_OUT) r = REG_OUT;
		else if (a >= SPIKE_BASE && a < SPIKE_BASE + AXON_SPAN) r = SPIKE_IN;
		else if (a >= LEARN_BASE && a < LEARN_BASE + AXON_SPAN) r = LEARN_RD;
		else if (a >= WEIGHT_BASE && a < WEIGHT_BASE + WT_SPAN) r = WEIGHT;
		return r;
	endfunction

	assign region   = decode(paddr_i);
	assign setup    = psel_i & ~penable_i;
	assign pready_o = 1'b1;

	// Error cases, judged in the setup cycle
	always_comb begin
		err = (region == BAD);
		if (pwrite_i) begin
			err = err | (region == REG_OUT) | (region == LEARN_RD);
			err = err | (busy_i & (region inside {SPIKE_IN, WEIGHT, REG_THRESH}));
		end
	end

	// Write strobe in the access cycle, gated by the registered error
	assign wr_ok = psel_i & penable_i & pwrite_i & ~pslverr_o;

	assign start_o         = wr_ok & (region == REG_CTRL) & pwdata_i[0];
	assign spk_wr_o.en     = wr_ok & (region == SPIKE_IN);
	assign spk_wr_o.axon   = paddr_i[2 +: AXON_AW];
	assign spk_wr_o.spike  = pwdata_i[0];
	// Broadcast, each neuron picks its own field
	assign wt_wr_o.en      = wr_ok & (region == WEIGHT);
	assign wt_wr_o.neuron  = paddr_i[WT_NRN_LSB +: NEURON_AW];
	assign wt_wr_o.axon    = paddr_i[2 +: AXON_AW];
	assign wt_wr_o.data    = pwdata_i[WEIGHT_W-1:0];
	assign lrn_addr_o      = paddr_i[2 +: AXON_AW];

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb begin
		rd_data = '0;
		case (region)
			REG_CTRL:   rd_data = {{(APB_DW-2){1'b0}}, done_q, busy_i};
			REG_THRESH: rd_data = {{(APB_DW-POT_W){thresh_o[POT_W-1]}}, thresh_o};
			REG_OUT:    rd_data = {{(APB_DW-NUM_NEURONS){1'b0}}, out_spikes_i};
			LEARN_RD:   rd_data = {{(APB_DW-1){1'b0}}, lrn_spike_i};
			default:    rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			prdata_o  <= '0;
			pslverr_o <= 1'b0;
			thresh_o  <= '0;
			done_q    <= 1'b0;
		end else begin
			// Response is ready for the access cycle
			if (setup) begin
				prdata_o <= rd_data;
			end
			pslverr_o <= setup & err;
			if (wr_ok && region == REG_THRESH) begin
				thresh_o <= pwdata_i[POT_W-1:0];
			end
			// Sticky until the next start
			if (start_o) done_q <= 1'b0;
			else if (eval_done_i) done_q <= 1'b1;
		end
	end

endmodule

// ==== in_spike_buf/in_spike_buf.sv ====
// Host spike writes must not overlap a scan; learn readback is combinational
`timescale 1ns/100ps

module in_spike_buf #(
	parameter int NUM_AXONS = snn_pkg::NUM_AXONS,
	parameter int AXON_AW   = snn_pkg::AXON_AW
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  snn_pkg::spk_wr_t      spk_wr_i,
	input  snn_pkg::axon_rd_t     rd_req_i,
	input  logic                  save_i,
	input  logic [AXON_AW-1:0]    lrn_addr_i,
	output snn_pkg::spike_beat_t  beat_o,
	output logic                  lrn_spike_o
);

	// Recall bits feed the scan, learn bits hold the last finished step
	logic [NUM_AXONS-1:0] rcl_q;
	logic [NUM_AXONS-1:0] lrn_q;

	// ----------------------------------------
	// Recall array and scan read
	// ----------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rcl_q  <= '0;
			beat_o <= '0;
		end else begin
			if (spk_wr_i.en) begin
				rcl_q[spk_wr_i.axon] <= spk_wr_i.spike;
			end
			// One beat per request, tags travel with the bit
			beat_o.valid <= rd_req_i.en;
			beat_o.last  <= rd_req_i.en & rd_req_i.last;
			beat_o.axon  <= rd_req_i.addr;
			beat_o.spike <= rcl_q[rd_req_i.addr];
		end
	end

	// ----------------------------------------
	// Learn array
	// ----------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lrn_q <= '0;
		end else if (save_i) begin
			// Snapshot of the whole recall array
			lrn_q <= rcl_q;
		end
	end

	assign lrn_spike_o = lrn_q[lrn_addr_i];

	// Host writes are blocked while the sequencer scans
	a_no_wr_during_scan: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(spk_wr_i.en && rd_req_i.en)
	);

endmodule

// ==== common/snn_pkg.sv ====
// Struct field widths follow these defaults, so the top level must keep the same sizes
package snn_pkg;

	// ----------------------------------------
	// Core sizes
	// ----------------------------------------
	localparam int NUM_AXONS   = 16;
	localparam int AXON_AW     = 4;
	localparam int NUM_NEURONS = 4;
	localparam int NEURON_AW   = 2;
	localparam int WEIGHT_W    = 8;
	localparam int POT_W       = 12;

	// APB bus widths
	localparam int APB_AW = 12;
	localparam int APB_DW = 32;

	// ----------------------------------------
	// Address map, byte addresses
	// ----------------------------------------
	localparam logic [APB_AW-1:0] ADDR_CTRL   = 12'h000;
	localparam logic [APB_AW-1:0] ADDR_THRESH = 12'h004;
	localparam logic [APB_AW-1:0] ADDR_OUT    = 12'h008;
	localparam logic [APB_AW-1:0] SPIKE_BASE  = 12'h100;
	localparam logic [APB_AW-1:0] LEARN_BASE  = 12'h200;
	localparam logic [APB_AW-1:0] WEIGHT_BASE = 12'h400;
	// One word per axon, 0x40 bytes per neuron block
	localparam int AXON_SPAN  = 4 * NUM_AXONS;
	localparam int WT_NRN_LSB = 6;
	localparam int WT_SPAN    = (1 << WT_NRN_LSB) * NUM_NEURONS;

	typedef enum logic [2:0] {
		REG_CTRL, REG_THRESH, REG_OUT, SPIKE_IN, LEARN_RD, WEIGHT, BAD
	} apb_region_e;

	typedef enum logic [1:0] {IDLE, SCAN, EVAL, SAVE} seq_state_e;

	// Scan request toward the spike buffer
	typedef struct packed {
		logic               en;
		logic               last;
		logic [AXON_AW-1:0] addr;
	} axon_rd_t;

	// Registered buffer read, broadcast to the neuron row
	typedef struct packed {
		logic               valid;
		logic               last;
		logic [AXON_AW-1:0] axon;
		logic               spike;
	} spike_beat_t;

	typedef struct packed {
		logic                       en;
		logic [NEURON_AW-1:0]       neuron;
		logic [AXON_AW-1:0]         axon;
		logic signed [WEIGHT_W-1:0] data;
	} wt_wr_t;

	typedef struct packed {
		logic               en;
		logic [AXON_AW-1:0] axon;
		logic               spike;
	} spk_wr_t;

endpackage
